// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_udp_tx
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/arp_lookup.sv ====
`timescale 1ns/1ps

module arp_lookup import udp_tx_pkg::*; (
    input  logic      logic_clk,
    input  logic      logic_rst,
    input  logic      frame_start_i,
    input  ip_addr_u  dst_ip_i,
    input  logic      frame_done_i,
    output ip_addr_u  arp_query_ip_o,
    output logic      arp_query_valid_o,
    input  logic      arp_query_ready_i,
    input  mac_addr_t arp_resp_mac_i,
    input  logic      arp_resp_valid_i,
    input  logic      arp_resp_err_i,
    output logic      arp_resp_ready_o,
    output mac_addr_t mac_o,
    output logic      mac_valid_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_QUERY,
        ST_WAIT,
        ST_DONE
    } arp_state_t;

    arp_state_t state;
    mac_addr_t  mac_q;

    // dst_ip_i is latched upstream and stays put for the whole frame
    assign arp_query_ip_o    = dst_ip_i;
    assign arp_query_valid_o = (state == ST_QUERY);
    assign arp_resp_ready_o  = (state == ST_WAIT);
    assign mac_valid_o       = (state == ST_DONE);
    assign mac_o             = mac_q;

    always_ff @(posedge logic_clk) begin
        if (arp_resp_ready_o && arp_resp_valid_i && !arp_resp_err_i) begin
            mac_q <= arp_resp_mac_i;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (frame_start_i) state <= ST_QUERY;
                ST_QUERY: if (arp_query_ready_i) state <= ST_WAIT;
                ST_WAIT: begin
                    if (arp_resp_valid_i) begin
                        state <= arp_resp_err_i ? ST_QUERY : ST_DONE;    // miss asks again
                    end
                end
                ST_DONE:  if (frame_done_i) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== source/frame_serializer.sv ====
`timescale 1ns/1ps

module frame_serializer import udp_tx_pkg::*; #(
    parameter logic [31:0] LOCAL_IP  = 32'hC0A8_006E,
    parameter logic [47:0] LOCAL_MAC = 48'hABCD_1234_5678,
    parameter logic [15:0] SRC_PORT  = 16'd8080,
    parameter logic [15:0] DST_PORT  = 16'd8080
) (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  frame_info_t info_i,
    input  logic        info_valid_i,
    input  mac_addr_t   mac_i,
    input  logic        mac_valid_i,
    input  byte_beat_t  fifo_beat_i,
    input  logic        fifo_empty_i,
    input  logic        net_ready_i,
    output logic        fifo_pop_o,
    output byte_beat_t  net_beat_o,
    output logic        net_valid_o,
    output logic        frame_done_o
);

    localparam int HDR_LEN = ETH_HEAD_LEN + IP_HEAD_LEN + UDP_HEAD_LEN;
    localparam int HCNT_W  = $clog2(HDR_LEN);

    // parts of both sums that only depend on parameters
    localparam logic [SUM_W-1:0] IP_CONST_SUM = SUM_W'(IP_VER_TOS) + SUM_W'(IP_FLAGS_FRAG)
                                              + SUM_W'(IP_TTL_PROTO) + SUM_W'(LOCAL_IP[31:16])
                                              + SUM_W'(LOCAL_IP[15:0]);
    localparam logic [SUM_W-1:0] UDP_CONST_SUM = SUM_W'(LOCAL_IP[31:16]) + SUM_W'(LOCAL_IP[15:0])
                                               + SUM_W'(IP_TTL_PROTO[7:0]) + SUM_W'(SRC_PORT)
                                               + SUM_W'(DST_PORT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FOLD,
        ST_HEAD,
        ST_PAY
    } ser_state_t;

    ser_state_t          state;
    logic [1:0]          fold_cnt;
    logic [HCNT_W-1:0]   hdr_cnt;
    logic [SUM_W-1:0]    ip_acc;
    logic [SUM_W-1:0]    udp_acc;
    logic [15:0]         ip_csum;
    logic [15:0]         udp_csum;
    logic [LEN_W-1:0]    ip_len;
    logic [LEN_W-1:0]    udp_len;
    logic [HDR_LEN*8-1:0] hdr_bits;
    logic [7:0]          hdr_byte;

    assign udp_len = info_i.len + LEN_W'(UDP_HEAD_LEN);
    assign ip_len  = info_i.len + LEN_W'(UDP_HEAD_LEN + IP_HEAD_LEN);

    // eth, ip and udp headers in wire order, first byte at the top
    assign hdr_bits = {mac_i, LOCAL_MAC, ETH_TYPE_IPV4,
                       IP_VER_TOS, ip_len,
                       16'h0000,                       // identification
                       IP_FLAGS_FRAG, IP_TTL_PROTO, ip_csum,
                       LOCAL_IP, info_i.dst_ip.octet,
                       SRC_PORT, DST_PORT, udp_len, udp_csum};

    assign hdr_byte = hdr_bits[(HDR_LEN - 1 - int'(hdr_cnt)) * 8 +: 8];

    always_comb begin
        if (state == ST_HEAD) begin
            net_beat_o.data = hdr_byte;
            net_beat_o.last = 1'b0;
            net_valid_o     = 1'b1;
        end else begin
            net_beat_o  = fifo_beat_i;
            net_valid_o = (state == ST_PAY) && !fifo_empty_i;
        end
    end

    assign fifo_pop_o   = (state == ST_PAY) && !fifo_empty_i && net_ready_i;
    assign frame_done_o = fifo_pop_o && fifo_beat_i.last;

    // sum, fold, fold, invert
    always_ff @(posedge logic_clk) begin
        if (state == ST_IDLE) begin
            ip_acc  <= IP_CONST_SUM + SUM_W'(ip_len)
                     + SUM_W'(info_i.dst_ip.half[1]) + SUM_W'(info_i.dst_ip.half[0]);
            udp_acc <= UDP_CONST_SUM + SUM_W'(udp_len) + SUM_W'(udp_len)
                     + SUM_W'(info_i.dst_ip.half[1]) + SUM_W'(info_i.dst_ip.half[0])
                     + info_i.sum;
        end else if (state == ST_FOLD) begin
            if (fold_cnt == 2'd2) begin
                ip_csum  <= ~ip_acc[15:0];
                udp_csum <= ~udp_acc[15:0];
            end else begin
                ip_acc  <= SUM_W'(ip_acc[31:16]) + SUM_W'(ip_acc[15:0]);
                udp_acc <= SUM_W'(udp_acc[31:16]) + SUM_W'(udp_acc[15:0]);
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            state    <= ST_IDLE;
            fold_cnt <= '0;
            hdr_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    fold_cnt <= '0;
                    hdr_cnt  <= '0;
                    if (info_valid_i && mac_valid_i) state <= ST_FOLD;
                end
                ST_FOLD: begin
                    fold_cnt <= fold_cnt + 1'b1;
                    if (fold_cnt == 2'd2) state <= ST_HEAD;
                end
                ST_HEAD: begin
                    if (net_ready_i) begin
                        if (hdr_cnt == HCNT_W'(HDR_LEN - 1)) begin
                            state <= ST_PAY;
                        end else begin
                            hdr_cnt <= hdr_cnt + 1'b1;
                        end
                    end
                end
                ST_PAY:  if (frame_done_o) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== source/payload_fifo.sv ====
`timescale 1ns/1ps

module payload_fifo import udp_tx_pkg::*; #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  logic       push_i,
    input  byte_beat_t push_beat_i,
    input  logic       pop_i,
    output byte_beat_t pop_beat_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    byte_beat_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o     = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o    = (count == '0);
    assign pop_beat_o = mem[rd_ptr];    // head entry, shown ahead of the pop

    always_ff @(posedge logic_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_beat_i;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== source/payload_summer.sv ====
`timescale 1ns/1ps

module payload_summer import udp_tx_pkg::*; #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  byte_beat_t  udp_beat_i,
    input  logic        udp_valid_i,
    input  ip_addr_u    udp_ip_i,
    input  logic        fifo_full_i,
    input  logic        frame_done_i,
    output logic        udp_ready_o,
    output logic        push_o,
    output logic        frame_start_o,
    output frame_info_t info_o,
    output logic        info_valid_o
);

    logic [LEN_W-1:0] byte_cnt;
    logic [SUM_W-1:0] raw_sum;
    logic [7:0]       hi_byte;    // upper half of the word being paired
    ip_addr_u         dst_ip;
    logic             pending;    // whole payload buffered, waiting to go out
    logic             accept;

    // frame never grows past the buffer, so the last byte always fits
    assign udp_ready_o   = !fifo_full_i && !pending && (byte_cnt < LEN_W'(FIFO_DEPTH));
    assign accept        = udp_valid_i && udp_ready_o;
    assign push_o        = accept;
    assign frame_start_o = accept && (byte_cnt == '0);

    assign info_o.len    = byte_cnt;
    assign info_o.sum    = raw_sum;
    assign info_o.dst_ip = dst_ip;
    assign info_valid_o  = pending;

    always_ff @(posedge logic_clk) begin
        if (frame_start_o) begin
            dst_ip <= udp_ip_i;
        end
        if (accept && !byte_cnt[0]) begin
            hi_byte <= udp_beat_i.data;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            byte_cnt <= '0;
            raw_sum  <= '0;
            pending  <= 1'b0;
        end else if (frame_done_i) begin
            byte_cnt <= '0;
            raw_sum  <= '0;
            pending  <= 1'b0;
        end else if (accept) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt[0]) begin
                raw_sum <= raw_sum + SUM_W'({hi_byte, udp_beat_i.data});
            end else if (udp_beat_i.last) begin
                raw_sum <= raw_sum + SUM_W'({udp_beat_i.data, 8'h00});    // odd tail, zero pad
            end
            pending <= udp_beat_i.last;
        end
    end

endmodule

// ==== source/udp_tx_pkg.sv ====
package udp_tx_pkg;

    // header sizes in bytes
    localparam int ETH_HEAD_LEN = 14;
    localparam int IP_HEAD_LEN  = 20;
    localparam int UDP_HEAD_LEN = 8;

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [15:0] IP_VER_TOS    = 16'h4500;    // version 4, ihl 5, tos 0
    localparam logic [15:0] IP_FLAGS_FRAG = 16'h4000;    // don't fragment
    localparam logic [15:0] IP_TTL_PROTO  = 16'h8011;    // ttl 0x80, proto udp

    localparam int LEN_W = 16;    // lengths and byte counters
    localparam int SUM_W = 32;    // raw checksum accumulator

    // one IPv4 address, read as bytes on the wire or as words for the checksum
    typedef union packed {
        logic [3:0][7:0]  octet;    // octet[3] goes out first
        logic [1:0][15:0] half;     // half[1] is the upper word
    } ip_addr_u;

    typedef logic [47:0] mac_addr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    typedef struct packed {
        logic [LEN_W-1:0] len;       // payload bytes
        logic [SUM_W-1:0] sum;       // unfolded payload word sum
        ip_addr_u         dst_ip;
    } frame_info_t;

endpackage

// ==== source/udp_tx_top.sv ====
`timescale 1ns/1ps

module udp_tx_top import udp_tx_pkg::*; #(
    parameter logic [31:0] LOCAL_IP   = 32'hC0A8_006E,
    parameter logic [47:0] LOCAL_MAC  = 48'hABCD_1234_5678,
    parameter logic [15:0] SRC_PORT   = 16'd8080,
    parameter logic [15:0] DST_PORT   = 16'd8080,
    parameter int          FIFO_DEPTH = 1024
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  byte_beat_t udp_beat_i,
    input  logic       udp_valid_i,
    input  ip_addr_u   udp_ip_i,
    output logic       udp_ready_o,
    output byte_beat_t net_beat_o,
    output logic       net_valid_o,
    input  logic       net_ready_i,
    output ip_addr_u   arp_query_ip_o,
    output logic       arp_query_valid_o,
    input  logic       arp_query_ready_i,
    input  mac_addr_t  arp_resp_mac_i,
    input  logic       arp_resp_valid_i,
    input  logic       arp_resp_err_i,
    output logic       arp_resp_ready_o
);

    logic        push;
    logic        fifo_pop;
    logic        fifo_full;
    logic        fifo_empty;
    byte_beat_t  fifo_beat;
    logic        frame_start;
    logic        frame_done;
    frame_info_t info;
    logic        info_valid;
    mac_addr_t   mac;
    logic        mac_valid;

    payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .logic_clk, .logic_rst,
        .push_i(push), .push_beat_i(udp_beat_i), .pop_i(fifo_pop),
        .pop_beat_o(fifo_beat), .full_o(fifo_full), .empty_o(fifo_empty)
    );

    payload_summer #(.FIFO_DEPTH(FIFO_DEPTH)) u_summer (
        .logic_clk, .logic_rst, .udp_beat_i, .udp_valid_i, .udp_ip_i,
        .fifo_full_i(fifo_full), .frame_done_i(frame_done), .udp_ready_o,
        .push_o(push), .frame_start_o(frame_start), .info_o(info), .info_valid_o(info_valid)
    );

    arp_lookup u_arp (
        .logic_clk, .logic_rst, .frame_start_i(frame_start), .dst_ip_i(info.dst_ip),
        .frame_done_i(frame_done), .arp_query_ip_o, .arp_query_valid_o, .arp_query_ready_i,
        .arp_resp_mac_i, .arp_resp_valid_i, .arp_resp_err_i, .arp_resp_ready_o,
        .mac_o(mac), .mac_valid_o(mac_valid)
    );

    frame_serializer #(
        .LOCAL_IP(LOCAL_IP), .LOCAL_MAC(LOCAL_MAC), .SRC_PORT(SRC_PORT), .DST_PORT(DST_PORT)
    ) u_serializer (
        .logic_clk, .logic_rst, .info_i(info), .info_valid_i(info_valid),
        .mac_i(mac), .mac_valid_i(mac_valid), .fifo_beat_i(fifo_beat),
        .fifo_empty_i(fifo_empty), .net_ready_i, .fifo_pop_o(fifo_pop),
        .net_beat_o, .net_valid_o, .frame_done_o(frame_done)
    );

endmodule

// ==== tb.f ====
source/udp_tx_pkg.sv
source/payload_fifo.sv
source/payload_summer.sv
source/arp_lookup.sv
source/frame_serializer.sv
source/udp_tx_top.sv
tb/tb_udp_tx.sv

// ==== tb/tb_udp_tx.sv ====
`timescale 1ns/1ps

module tb_udp_tx import udp_tx_pkg::*; ();

    localparam logic [31:0] LOCAL_IP   = 32'h0A00_0001;
    localparam logic [47:0] LOCAL_MAC  = 48'h0200_0000_0001;
    localparam logic [15:0] SRC_PORT   = 16'd5000;
    localparam logic [15:0] DST_PORT   = 16'd6000;
    localparam int          FIFO_DEPTH = 64;
    localparam logic [31:0] IP_A       = 32'h0A00_0002;
    localparam logic [31:0] IP_B       = 32'h0A00_0003;
    localparam int          TIMEOUT    = 2000;    // cycles per wait

    typedef logic [7:0] byte_q [$];

    logic       logic_clk;
    logic       logic_rst;
    byte_beat_t udp_beat_i;
    logic       udp_valid_i;
    ip_addr_u   udp_ip_i;
    logic       udp_ready_o;
    byte_beat_t net_beat_o;
    logic       net_valid_o;
    logic       net_ready_i = 1'b0;
    ip_addr_u   arp_query_ip_o;
    logic       arp_query_valid_o;
    logic       arp_query_ready_i = 1'b1;    // cache always takes queries
    mac_addr_t  arp_resp_mac_i = '0;
    logic       arp_resp_valid_i = 1'b0;
    logic       arp_resp_err_i = 1'b0;
    logic       arp_resp_ready_o;

    byte_beat_t  rx_q [$];    // beats seen on the network side
    logic [31:0] lfsr_state;
    logic        random_ready = 1'b0;
    int          miss_left = 0;
    int          query_cnt = 0;
    ip_addr_u    exp_ip;
    int          err_cnt = 0;
    int          tests_run = 0;

    udp_tx_top #(
        .LOCAL_IP(LOCAL_IP), .LOCAL_MAC(LOCAL_MAC), .SRC_PORT(SRC_PORT),
        .DST_PORT(DST_PORT), .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .logic_clk, .logic_rst, .udp_beat_i, .udp_valid_i, .udp_ip_i, .udp_ready_o,
        .net_beat_o, .net_valid_o, .net_ready_i, .arp_query_ip_o, .arp_query_valid_o,
        .arp_query_ready_i, .arp_resp_mac_i, .arp_resp_valid_i, .arp_resp_err_i,
        .arp_resp_ready_o
    );

    always #20 logic_clk = ~logic_clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = b ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
        return b;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) b = {b[6:0], lfsr_bit()};
        return b;
    endfunction

    // small ARP table of the cache model
    function automatic mac_addr_t cache_mac(input ip_addr_u ip);
        case (ip)
            IP_A:    return 48'h00AA_BBCC_0002;
            IP_B:    return 48'h00AA_BBCC_0003;
            default: return 48'h00EE_EEEE_EEEE;
        endcase
    endfunction

    function automatic logic [15:0] ones_fold(input logic [31:0] s);
        s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
        s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
        return ~s[15:0];
    endfunction

    task automatic report_failure(input string what);
        $display("FAIL at %0d ns: %s", $time, what);
        err_cnt++;
    endtask

    task automatic check_beat(input string name, input byte_beat_t got, input byte_beat_t want);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s got data %h last %b, expected data %h last %b",
                     $time, name, got.data, got.last, want.data, want.last);
            err_cnt++;
        end
    endtask

    task automatic check_ip(input string name, input ip_addr_u got, input ip_addr_u want);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s got %h expected %h", $time, name, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR at %0d ns: %s got %b expected %b", $time, name, got, want);
            err_cnt++;
        end
    endtask

    task automatic log_result(input string name, input int start);
        tests_run++;
        $display("%-20s %s", name, (err_cnt == start) ? "ok" : "failed");
    endtask

    // network sink, ready from the LFSR when back-pressure is on
    always @(negedge logic_clk) begin
        net_ready_i = random_ready ? lfsr_bit() : 1'b1;
        if (!logic_rst && net_valid_o && net_ready_i) rx_q.push_back(net_beat_o);
    end

    // ARP cache model, answers one cycle after resp ready
    always @(negedge logic_clk) begin
        if (arp_resp_valid_i && miss_left > 0) miss_left--;    // previous answer was taken
        if (arp_query_valid_o) begin
            query_cnt++;
            check_ip("arp_query_ip_o", arp_query_ip_o, exp_ip);
        end
        arp_resp_valid_i = arp_resp_ready_o;
        arp_resp_err_i   = arp_resp_ready_o && (miss_left > 0);
        arp_resp_mac_i   = arp_resp_err_i ? '0 : cache_mac(arp_query_ip_o);
    end

    // expected frame bytes straight from the header and checksum rules
    task automatic build_frame(input byte_q pay, input ip_addr_u dst, input mac_addr_t mac,
                               output byte_q fr);
        logic [31:0]  ip_sum;
        logic [31:0]  udp_sum;
        logic [15:0]  ip_len;
        logic [15:0]  udp_len;
        logic [7:0]   lo;
        logic [335:0] hdr;
        udp_len = 16'(pay.size() + 8);
        ip_len  = 16'(pay.size() + 28);
        ip_sum  = 32'h4500 + 32'(ip_len) + 32'h4000 + 32'h8011
                + 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0])
                + 32'(dst.half[1]) + 32'(dst.half[0]);
        udp_sum = 32'(LOCAL_IP[31:16]) + 32'(LOCAL_IP[15:0]) + 32'(dst.half[1])
                + 32'(dst.half[0]) + 32'h0011 + 32'(udp_len)    // pseudo header
                + 32'(SRC_PORT) + 32'(DST_PORT) + 32'(udp_len);
        for (int i = 0; i < pay.size(); i += 2) begin
            lo = (i + 1 < pay.size()) ? pay[i + 1] : 8'h00;    // pad an odd tail
            udp_sum += 32'({pay[i], lo});
        end
        hdr = {mac, LOCAL_MAC, 16'h0800, 16'h4500, ip_len, 16'h0000, 16'h4000, 16'h8011,
               ones_fold(ip_sum), LOCAL_IP, dst, SRC_PORT, DST_PORT, udp_len,
               ones_fold(udp_sum)};
        fr = {};
        for (int i = 41; i >= 0; i--) fr.push_back(hdr[i*8 +: 8]);
        foreach (pay[i]) fr.push_back(pay[i]);
    endtask

    task automatic send_payload(input byte_q pay, input ip_addr_u ip);
        int t;
        exp_ip = ip;
        foreach (pay[i]) begin
            udp_beat_i.data = pay[i];
            udp_beat_i.last = (i == pay.size() - 1);
            udp_ip_i        = ip;
            udp_valid_i     = 1'b1;
            t = 0;
            while (!udp_ready_o && t < TIMEOUT) begin
                @(negedge logic_clk);
                t++;
            end
            if (!udp_ready_o) begin
                report_failure("udp_ready_o stayed low, a payload byte was never taken");
                break;
            end
            @(negedge logic_clk);    // byte taken on the rising edge before this
        end
        udp_valid_i = 1'b0;
    endtask

    task automatic check_frame(input string name, input byte_q exp);
        int         t;
        byte_beat_t want;
        byte_beat_t got;
        t = 0;
        while (rx_q.size() < exp.size() && t < TIMEOUT) begin
            @(negedge logic_clk);
            t++;
        end
        if (rx_q.size() < exp.size()) begin
            report_failure($sformatf("%s: only %0d of %0d frame bytes came out",
                                     name, rx_q.size(), exp.size()));
        end else begin
            foreach (exp[i]) begin
                want.data = exp[i];
                want.last = (i == exp.size() - 1);
                got = rx_q.pop_front();
                check_beat($sformatf("%s net_beat_o[%0d]", name, i), got, want);
            end
        end
    endtask

    task automatic run_frame(input string name, input ip_addr_u ip, input int n, input logic bp);
        byte_q pay;
        byte_q exp;
        repeat (n) pay.push_back(rand_byte());
        build_frame(pay, ip, cache_mac(ip), exp);
        random_ready = bp;
        send_payload(pay, ip);
        check_frame(name, exp);
        random_ready = 1'b0;
    endtask

    task automatic reset_values();
        int start;
        start = err_cnt;
        check_bit("udp_ready_o", udp_ready_o, 1'b1);
        check_bit("net_valid_o", net_valid_o, 1'b0);
        check_bit("arp_query_valid_o", arp_query_valid_o, 1'b0);
        check_bit("arp_resp_ready_o", arp_resp_ready_o, 1'b0);
        log_result("reset_values", start);
    endtask

    task automatic even_payload();
        int start;
        start = err_cnt;
        run_frame("even", IP_A, 16, 1'b0);
        repeat (4) @(negedge logic_clk);
        if (rx_q.size() != 0) report_failure("extra bytes after the 58 byte frame");
        log_result("even_payload", start);
    endtask

    task automatic odd_payload();
        int start;
        start = err_cnt;
        run_frame("odd", IP_B, 17, 1'b0);
        log_result("odd_payload", start);
    endtask

    task automatic random_backpressure();
        int start;
        start = err_cnt;
        run_frame("backpressure", IP_A, 23, 1'b1);
        log_result("random_backpressure", start);
    endtask

    task automatic arp_retry();
        int start;
        start = err_cnt;
        miss_left = 2;
        query_cnt = 0;
        run_frame("arp_retry", IP_B, 10, 1'b0);
        if (query_cnt != 3) report_failure($sformatf("expected 3 ARP queries, saw %0d", query_cnt));
        log_result("arp_retry", start);
    endtask

    task automatic back_to_back();
        byte_q pay1;
        byte_q pay2;
        byte_q exp1;
        byte_q exp2;
        int    start;
        int    t;
        start = err_cnt;
        repeat (12) pay1.push_back(rand_byte());
        repeat (9) pay2.push_back(rand_byte());
        build_frame(pay1, IP_A, cache_mac(IP_A), exp1);
        build_frame(pay2, IP_B, cache_mac(IP_B), exp2);
        send_payload(pay1, IP_A);
        fork
            send_payload(pay2, IP_B);
            begin
                t = 0;
                // input held off until frame 1 has left
                while (rx_q.size() < exp1.size() && t < TIMEOUT) begin
                    check_bit("udp_ready_o", udp_ready_o, 1'b0);
                    @(negedge logic_clk);
                    t++;
                end
            end
        join
        check_frame("frame 1", exp1);
        check_frame("frame 2", exp2);
        log_result("back_to_back", start);
    endtask

    initial begin
        logic_clk   = 1'b0;
        logic_rst   = 1'b1;
        udp_beat_i  = '0;
        udp_valid_i = 1'b0;
        udp_ip_i    = '0;
        exp_ip      = '0;
        lfsr_state  = 32'd70719;
        repeat (8) @(negedge logic_clk);
        logic_rst = 1'b0;
        @(negedge logic_clk);
        reset_values();
        even_payload();
        odd_payload();
        random_backpressure();
        arp_retry();
        back_to_back();
        $display("%0d tests run, %0d errors", tests_run, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
